//--- spi_master_params.svh
`ifndef SPI_MASTER_PARAMS_SVH
`define SPI_MASTER_PARAMS_SVH

// transfer word width in bits
`define SPI_DATA_BITS 8

// clk cycles per sck half-period
`define SPI_CLK_DIV 2

// default bus mode is mode 0 with msb first
`define SPI_CPOL 0
`define SPI_CPHA 0
`define SPI_LSBFE 0

// slave-select lines on the bus
`define SPI_NUM_CS 4

`endif

//--- spi_master_pkg.sv
`default_nettype none

`include "spi_master_params.svh"

package spi_master_pkg;

	// one transfer word
	typedef logic [`SPI_DATA_BITS-1:0] spi_word_t;

	// index of the addressed slave
	typedef logic [$clog2(`SPI_NUM_CS)-1:0] spi_cs_sel_t;

	// select lines, active low
	typedef logic [`SPI_NUM_CS-1:0] spi_cs_vec_t;

endpackage

`default_nettype wire

//--- spi_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_xfer_if;

	logic start;  // one-cycle request pulse
	logic busy;  // core not idle
	logic done;  // one-cycle completion pulse
	spi_master_pkg::spi_word_t tx_data;  // byte to shift out
	spi_master_pkg::spi_word_t rx_data;  // valid while done

	modport ctrl (
		output start,
		output tx_data,
		input  busy,
		input  done,
		input  rx_data
	);

	modport core (
		input  start,
		input  tx_data,
		output busy,
		output done,
		output rx_data
	);

endinterface

`default_nettype wire

//--- spi_edge_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_edge_if;

	logic run;  // high for the whole transfer state
	logic sck_lvl;  // current sck level
	logic shift_stb;  // drive next mosi bit at this clk edge
	logic sample_stb;  // capture miso at this clk edge

	modport gen (
		input  run,
		output sck_lvl,
		output shift_stb,
		output sample_stb
	);

	modport core (
		output run,
		input  shift_stb,
		input  sample_stb
	);

endinterface

`default_nettype wire

//--- spi_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_params.svh"

module spi_clk_gen #(
	parameter int CPOL    = `SPI_CPOL,
	parameter int CPHA    = `SPI_CPHA,
	parameter int CLK_DIV = `SPI_CLK_DIV
) (
	input  logic    clk,
	input  logic    rst,
	spi_edge_if.gen edge_bus
);

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic IDLE_LVL = (CPOL != 0) ? 1'b1 : 1'b0;

	logic [CNT_W-1:0] half_cnt;  // clk cycles into current half-period
	logic sck_q;
	logic tick;  // sck toggles at the end of this cycle
	logic lead_edge;
	logic trail_edge;

	assign tick = edge_bus.run && (half_cnt == CNT_W'(CLK_DIV - 1));

	// leading edge leaves the idle level, trailing edge returns to it
	assign lead_edge = tick && (sck_q == IDLE_LVL);
	assign trail_edge = tick && (sck_q != IDLE_LVL);

	always_ff @(posedge clk) begin
		if (!rst) begin
			half_cnt <= '0;
			sck_q <= IDLE_LVL;
		end else if (!edge_bus.run) begin
			half_cnt <= '0;  // restart divider for next transfer
			sck_q <= IDLE_LVL;
		end else if (tick) begin
			half_cnt <= '0;
			sck_q <= ~sck_q;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	assign edge_bus.sck_lvl = sck_q;

	// cpha 0 samples on leading edges, cpha 1 on trailing edges
	assign edge_bus.sample_stb = (CPHA != 0) ? trail_edge : lead_edge;
	assign edge_bus.shift_stb = (CPHA != 0) ? lead_edge : trail_edge;

endmodule

`default_nettype wire

//--- spi_shift_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_params.svh"

module spi_shift_core #(
	parameter int CPHA  = `SPI_CPHA,
	parameter int LSBFE = `SPI_LSBFE
) (
	input  logic     clk,
	input  logic     rst,
	spi_xfer_if.core xfer,
	spi_edge_if.core edge_bus,
	output logic     mosi,
	input  logic     miso
);

	localparam int DATA_BITS = `SPI_DATA_BITS;
	localparam int BIT_W = $clog2(DATA_BITS + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOAD,
		S_TRANS,
		S_ACK
	} state_t;

	state_t state;
	logic [BIT_W-1:0] bit_cnt;  // sample strobes seen so far
	spi_master_pkg::spi_word_t tx_sr;
	spi_master_pkg::spi_word_t rx_sr;
	spi_master_pkg::spi_word_t tx_next;
	spi_master_pkg::spi_word_t rx_next;
	logic out_bit;
	logic last_edge;  // final sck edge of the byte
	logic finish;
	logic tx_step;  // put next bit on mosi

	assign out_bit = (LSBFE != 0) ? tx_sr[0] : tx_sr[DATA_BITS-1];
	assign tx_next = (LSBFE != 0) ? (tx_sr >> 1) : (tx_sr << 1);
	assign rx_next = (LSBFE != 0) ? {miso, rx_sr[DATA_BITS-1:1]}
		: {rx_sr[DATA_BITS-2:0], miso};

	// cpha 1 ends on the last sample, cpha 0 on the trailing edge after it
	assign last_edge = (CPHA != 0)
		? (edge_bus.sample_stb && (bit_cnt == BIT_W'(DATA_BITS - 1)))
		: (edge_bus.shift_stb && (bit_cnt == BIT_W'(DATA_BITS)));
	assign finish = (state == S_TRANS) && last_edge;

	// with cpha 0 the first bit goes out during load
	assign tx_step = ((state == S_LOAD) && (CPHA == 0))
		|| ((state == S_TRANS) && edge_bus.shift_stb && !last_edge);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= S_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (xfer.start) begin
						state <= S_LOAD;
						bit_cnt <= '0;
					end
				end
				S_LOAD: begin
					state <= S_TRANS;
				end
				S_TRANS: begin
					if (edge_bus.sample_stb)
						bit_cnt <= bit_cnt + 1'b1;
					if (last_edge)
						state <= S_ACK;
				end
				default: begin
					state <= S_IDLE;  // ack lasts one cycle
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst)
			mosi <= 1'b1;
		else if (finish)
			mosi <= 1'b1;  // line idles high between bytes
		else if (tx_step)
			mosi <= out_bit;
	end

	always_ff @(posedge clk) begin
		if ((state == S_IDLE) && xfer.start)
			tx_sr <= xfer.tx_data;
		else if (tx_step)
			tx_sr <= tx_next;
		if ((state == S_TRANS) && edge_bus.sample_stb)
			rx_sr <= rx_next;
	end

	assign edge_bus.run = (state == S_TRANS);
	assign xfer.busy = (state != S_IDLE);
	assign xfer.done = (state == S_ACK);
	assign xfer.rx_data = rx_sr;

endmodule

`default_nettype wire

//--- spi_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module spi_req_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        req,
	output logic                        ack,
	input  spi_master_pkg::spi_word_t   wr_data,
	input  spi_master_pkg::spi_cs_sel_t cs_sel,
	output spi_master_pkg::spi_word_t   rd_data,
	output spi_master_pkg::spi_cs_vec_t cs_n,
	spi_xfer_if.ctrl                    xfer
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SEL,
		S_WAIT,
		S_HOLD
	} state_t;

	state_t state;
	spi_master_pkg::spi_cs_vec_t cs_dec;  // one-hot low decode of cs_sel

	assign cs_dec = ~(spi_master_pkg::spi_cs_vec_t'(1) << cs_sel);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= S_IDLE;
			cs_n <= '1;
		end else begin
			case (state)
				S_IDLE: begin
					if (req) begin
						state <= S_SEL;
						cs_n <= cs_dec;  // select stays put until release
					end
				end
				S_SEL: begin
					if (!xfer.busy)
						state <= S_WAIT;
				end
				S_WAIT: begin
					if (xfer.done)
						state <= S_HOLD;
				end
				default: begin
					if (!req) begin
						state <= S_IDLE;
						cs_n <= '1;  // release together with ack
					end
				end
			endcase
		end
	end

	// received byte held for the host
	always_ff @(posedge clk) begin
		if ((state == S_WAIT) && xfer.done)
			rd_data <= xfer.rx_data;
	end

	// one start per request and only into an idle core
	assign xfer.start = (state == S_SEL) && !xfer.busy;
	assign xfer.tx_data = wr_data;  // host keeps it stable under req

	assign ack = (state == S_HOLD);

endmodule

`default_nettype wire

//--- spi_master_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_params.svh"

module spi_master_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        req,
	output logic                        ack,
	input  spi_master_pkg::spi_word_t   wr_data,
	input  spi_master_pkg::spi_cs_sel_t cs_sel,
	output spi_master_pkg::spi_word_t   rd_data,
	output spi_master_pkg::spi_cs_vec_t cs_n,
	output logic                        sck,
	output logic                        mosi,
	input  logic                        miso
);

	spi_xfer_if xfer_bus ();  // controller to shift core
	spi_edge_if edge_bus ();  // clock generator to shift core

	spi_req_ctrl u_req_ctrl (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.ack     (ack),
		.wr_data (wr_data),
		.cs_sel  (cs_sel),
		.rd_data (rd_data),
		.cs_n    (cs_n),
		.xfer    (xfer_bus.ctrl)
	);

	spi_clk_gen #(
		.CPOL    (`SPI_CPOL),
		.CPHA    (`SPI_CPHA),
		.CLK_DIV (`SPI_CLK_DIV)
	) u_clk_gen (
		.clk      (clk),
		.rst      (rst),
		.edge_bus (edge_bus.gen)
	);

	spi_shift_core #(
		.CPHA  (`SPI_CPHA),
		.LSBFE (`SPI_LSBFE)
	) u_shift_core (
		.clk      (clk),
		.rst      (rst),
		.xfer     (xfer_bus.core),
		.edge_bus (edge_bus.core),
		.mosi     (mosi),
		.miso     (miso)
	);

	assign sck = edge_bus.sck_lvl;  // registered in the generator

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		rst = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b1;  // released just after the fourth edge
	end

endmodule

`default_nettype wire

//--- spi_slave_bfm.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_params.svh"

module spi_slave_bfm (
	input  logic                        sck,
	input  logic                        mosi,
	output logic                        miso,
	input  spi_master_pkg::spi_cs_vec_t cs_n,
	input  spi_master_pkg::spi_cs_sel_t sel,
	input  spi_master_pkg::spi_word_t   reply,
	output spi_master_pkg::spi_word_t   rx_byte,
	output int                          rise_cnt
);

	localparam int DATA_BITS = `SPI_DATA_BITS;

	logic sel_n;  // select line of the current transfer
	logic sel_prev;
	logic sck_prev;
	int bit_idx;

	assign sel_n = cs_n[sel];

	// mode 0 msb first slave that presents on select and falling sck and samples on rising sck
	initial begin
		miso = 1'b1;
		rx_byte = '0;
		rise_cnt = 0;
		bit_idx = 0;
		sel_prev = 1'b1;
		sck_prev = 1'b0;
		forever begin
			@(sck or sel_n);
			if (!sel_n && sel_prev) begin
				bit_idx = DATA_BITS - 1;
				miso = reply[bit_idx];  // first bit before any edge
				rx_byte = '0;
				rise_cnt = 0;
			end else if (!sel_n && sck && !sck_prev) begin
				rx_byte = {rx_byte[DATA_BITS-2:0], mosi};
				rise_cnt = rise_cnt + 1;
			end else if (!sel_n && !sck && sck_prev && bit_idx > 0) begin
				bit_idx = bit_idx - 1;
				miso = reply[bit_idx];
			end
			sel_prev = sel_n;
			sck_prev = sck;
		end
	end

endmodule

`default_nettype wire

//--- spi_master_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_params.svh"

module spi_master_tb;

	localparam int ACK_LIMIT = 80;  // cycles from req to ack before giving up
	localparam int CYCLES_PER_LINE = 60;

	logic clk;
	logic rst;
	logic req;
	logic ack;
	spi_master_pkg::spi_word_t wr_data;
	spi_master_pkg::spi_cs_sel_t cs_sel;
	spi_master_pkg::spi_word_t rd_data;
	spi_master_pkg::spi_cs_vec_t cs_n;
	logic sck;
	logic mosi;
	logic miso;

	spi_master_pkg::spi_word_t reply_byte;  // what the slave sends back
	spi_master_pkg::spi_word_t slave_rx;
	int rise_cnt;

	spi_master_pkg::spi_cs_sel_t sel_q[$];
	spi_master_pkg::spi_word_t wr_q[$];
	spi_master_pkg::spi_word_t rep_q[$];

	int errors;
	int checks;
	int seed;
	bit loaded;

	tb_clk_gen u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	spi_master_top DUT (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.ack     (ack),
		.wr_data (wr_data),
		.cs_sel  (cs_sel),
		.rd_data (rd_data),
		.cs_n    (cs_n),
		.sck     (sck),
		.mosi    (mosi),
		.miso    (miso)
	);

	spi_slave_bfm u_slave (
		.sck      (sck),
		.mosi     (mosi),
		.miso     (miso),
		.cs_n     (cs_n),
		.sel      (cs_sel),
		.reply    (reply_byte),
		.rx_byte  (slave_rx),
		.rise_cnt (rise_cnt)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	// all lines high except the addressed one
	function automatic spi_master_pkg::spi_cs_vec_t select_pattern(
		input spi_master_pkg::spi_cs_sel_t sel);
		spi_master_pkg::spi_cs_vec_t vec;
		vec = '1;
		vec[sel] = 1'b0;
		return vec;
	endfunction

	task automatic load_stimulus();
		int fd;
		int code;
		string line;
		logic [31:0] sel_v;
		logic [31:0] wr_v;
		logic [31:0] rep_v;
		fd = $fopen("spi_master_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file spi_master_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0 && line.getc(0) != "#") begin
					if ($sscanf(line, "%h %h %h", sel_v, wr_v, rep_v) == 3) begin
						sel_q.push_back(spi_master_pkg::spi_cs_sel_t'(sel_v));
						wr_q.push_back(spi_master_pkg::spi_word_t'(wr_v));
						rep_q.push_back(spi_master_pkg::spi_word_t'(rep_v));
					end
				end
			end
			$fclose(fd);
			if (sel_q.size() == 0) begin
				errors++;
				$display("the stimulus file holds no transfers");
			end
		end
	endtask

	// starts and ends at a sample point 1 ns after a rising edge
	task automatic run_transfer(input int idx);
		int waited;
		int hold;
		int gap;
		spi_master_pkg::spi_cs_vec_t exp_cs;
		exp_cs = select_pattern(sel_q[idx]);
		cs_sel = sel_q[idx];
		wr_data = wr_q[idx];
		reply_byte = rep_q[idx];
		req = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
			check_value("cs_n", 32'(cs_n), 32'(exp_cs));
		end while (!ack && waited < ACK_LIMIT);
		if (!ack) begin
			errors++;
			$display("transfer %0d got no ack within %0d cycles of req", idx, ACK_LIMIT);
		end else begin
			check_value("rd_data", 32'(rd_data), 32'(rep_q[idx]));
			check_value("slave_rx", 32'(slave_rx), 32'(wr_q[idx]));
			hold = $unsigned($random(seed)) % 8;
			repeat (hold) begin
				@(posedge clk);
				#1;
				check_value("ack", 32'(ack), 32'd1);
				check_value("sck", 32'(sck), 32'd0);  // idle while host holds req
				check_value("mosi", 32'(mosi), 32'd1);
				check_value("cs_n", 32'(cs_n), 32'(exp_cs));
			end
			check_value("sck_rises", 32'(rise_cnt), 32'(`SPI_DATA_BITS));
		end
		req = 1'b0;
		@(posedge clk);
		#1;
		check_value("ack", 32'(ack), 32'd0);
		check_value("cs_n", 32'(cs_n), 32'(spi_master_pkg::spi_cs_vec_t'('1)));
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		req = 1'b0;
		wr_data = '0;
		cs_sel = '0;
		reply_byte = '0;
		errors = 0;
		checks = 0;
		seed = 35271;
		loaded = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		wait (rst === 1'b1);
		@(posedge clk);
		#1;
		check_value("ack", 32'(ack), 32'd0);  // idle state after reset
		check_value("cs_n", 32'(cs_n), 32'(spi_master_pkg::spi_cs_vec_t'('1)));
		check_value("sck", 32'(sck), 32'd0);
		check_value("mosi", 32'(mosi), 32'd1);
		for (int i = 0; i < sel_q.size(); i++)
			run_transfer(i);
		$display("%0d transfers, %0d checks, %0d errors", sel_q.size(), checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog sized from the number of transfers
	initial begin
		wait (loaded);
		repeat (sel_q.size() * CYCLES_PER_LINE + 100) @(posedge clk);
		$display("watchdog expired, the transfers did not complete in time");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- spi_master_stimulus.txt
# columns: cs_sel host_byte slave_reply, all hex
# one transfer per line
0 a5 5a
1 3c c3
2 ff 00
3 00 ff
0 80 01
1 01 80
2 55 aa
3 aa 55
0 12 34
1 fe 7f
2 c9 e1
3 6b 9d
1 0f f0
3 f0 0f
2 47 b2
0 d8 26

//--- spi_master.f
+incdir+.
spi_master_pkg.sv
spi_xfer_if.sv
spi_edge_if.sv
spi_clk_gen.sv
spi_shift_core.sv
spi_req_ctrl.sv
spi_master_top.sv
tb_clk_gen.sv
spi_slave_bfm.sv
spi_master_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module spi_master_tb -f spi_master.f \
	&& ./obj_dir/Vspi_master_tb | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }

grep -qx "Test OK" sim.log && exit 0 || exit 1
